//--- verilog/dm_split_pkg.sv
// ========================================
// Types and constants for the DM request splitter
// REQ_MAX_BYTES must be a power of two no larger than PAGE_BYTES
// Write payload is not carried and every request is a single header flit
// ========================================

`default_nettype none

package dm_split_pkg;

    // ========================================
    // Splitting constants
    // ========================================

    // Largest request that leaves the splitter, in bytes
    localparam int unsigned REQ_MAX_BYTES = 256;

    // No request may cross a boundary of this size
    localparam int unsigned PAGE_BYTES = 4096;

    // Bit offsets within one REQ_MAX_BYTES chunk and within one page
    localparam int unsigned REQ_OFS_W = $clog2(REQ_MAX_BYTES);
    localparam int unsigned PAGE_OFS_W = $clog2(PAGE_BYTES);

    // Marker bit within the 64-bit metadata
    // Set on the piece that completes the original request
    localparam int unsigned DM_METADATA_BIT = 63;

    // Header field widths
    localparam int unsigned LEN_W = 24;
    localparam int unsigned ADDR_W = 64;

    // fmt_type codes of 4DW memory read and memory write
    localparam logic [7:0] FMT_MRD = 8'h20;
    localparam logic [7:0] FMT_MWR = 8'h60;

    typedef logic [LEN_W-1:0] t_req_len;
    typedef logic [ADDR_W-1:0] t_req_addr;

    // ========================================
    // Stream types
    // ========================================

    // Request header, valid on the first flit of a packet only
    typedef struct packed {
        logic [7:0]  fmt_type;
        logic [9:0]  tag;
        t_req_len    length;
        t_req_addr   host_addr;
        logic [63:0] metadata;
    } t_req_hdr;

    // Side-band bits that travel with every flit
    typedef struct packed {
        logic dm_mode;
        logic commit_req;
    } t_tx_user;

    // One beat of the TX stream
    // Non-first flits reuse the hdr field as raw payload bits
    typedef struct packed {
        t_req_hdr hdr;
        t_tx_user user;
        logic     last;
    } t_tx_flit;

    // Decode flags that accompany a flit into the splitter
    typedef struct packed {
        logic sop;
        logic is_mrd;
        logic is_mwr;
        logic needs_split;
    } t_flit_class;

endpackage

`default_nettype wire

//--- verilog/axis_skid_stage.sv
// ========================================
// Two-entry skid buffer for the TX flit stream
// Accepts one beat per cycle with o_ready driven from registers only
// o_ready stays low until the first cycle after reset release
// ========================================

`default_nettype none

module axis_skid_stage (
    input  wire                     clk,
    input  wire                     rst_n,

    // Upstream side
    input  wire                     i_valid,
    input  wire dm_split_pkg::t_tx_flit i_flit,
    output logic                    o_ready,

    // Downstream side
    output logic                    o_valid,
    output dm_split_pkg::t_tx_flit  o_flit,
    input  wire                     i_ready
);

    import dm_split_pkg::*;

    // Main register drives the output, skid register catches a stalled beat
    logic     main_valid;
    logic     skid_valid;
    logic     ready_en;
    logic     main_free;
    logic     in_beat;
    t_tx_flit main_flit;
    t_tx_flit skid_flit;

    // Main register can take new data when empty or when it drains this cycle
    assign main_free = !main_valid || i_ready;

    // Ready is a function of registered state only
    assign o_ready = ready_en && !skid_valid;
    assign in_beat = i_valid && o_ready;

    assign o_valid = main_valid;
    assign o_flit  = main_flit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            ready_en   <= 1'b0;
        end else begin
            ready_en <= 1'b1;
            if (main_free) begin
                // The skid entry always drains first to keep order
                main_valid <= skid_valid || in_beat;
                skid_valid <= 1'b0;
            end else if (in_beat) begin
                // Output stalled, so the in-flight beat lands in the skid entry
                skid_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (main_free) begin
            main_flit <= skid_valid ? skid_flit : i_flit;
        end
        if (!main_free && !skid_valid) begin
            skid_flit <= i_flit;
        end
    end

endmodule

`default_nettype wire

//--- verilog/dm_hdr_classify.sv
// ========================================
// Packet start tracking and header decode
// Purely combinational from i_flit to o_class, apart from the sop state
// Only first flits in DM mode are ever classed as MRd or MWr
// ========================================

`default_nettype none

module dm_hdr_classify (
    input  wire                         clk,
    input  wire                         rst_n,

    input  wire dm_split_pkg::t_tx_flit i_flit,
    // High when i_flit transfers this cycle
    input  wire                         i_beat,

    output dm_split_pkg::t_flit_class   o_class
);

    import dm_split_pkg::*;

    // One extra bit so that page offset plus length cannot wrap
    typedef logic [LEN_W:0] t_page_end;

    logic      sop;
    logic      dm_req;
    logic      is_mrd;
    logic      is_mwr;
    t_page_end page_end;

    // The next flit starts a packet when the current one was last
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sop <= 1'b1;
        end else if (i_beat) begin
            sop <= i_flit.last;
        end
    end

    // ========================================
    // Header decode
    // ========================================

    // Header fields mean something only on the first flit of a DM packet
    assign dm_req = sop && i_flit.user.dm_mode;
    assign is_mrd = dm_req && (i_flit.hdr.fmt_type == FMT_MRD);
    assign is_mwr = dm_req && (i_flit.hdr.fmt_type == FMT_MWR);

    // End of the request measured from the start of its page
    assign page_end = t_page_end'(i_flit.hdr.host_addr[PAGE_OFS_W-1:0])
                    + t_page_end'(i_flit.hdr.length);

    always_comb begin
        o_class.sop    = sop;
        o_class.is_mrd = is_mrd;
        o_class.is_mwr = is_mwr;
        // Too long for one piece, or running past the page end
        o_class.needs_split = (is_mrd || is_mwr)
                            && ((i_flit.hdr.length > t_req_len'(REQ_MAX_BYTES))
                                || (page_end > t_page_end'(PAGE_BYTES)));
    end

endmodule

`default_nettype wire

//--- verilog/dm_req_splitter.sv
// ========================================
// Splits DM memory requests into pieces of at most REQ_MAX_BYTES
// Each piece keeps the tag, so unique tags must be applied downstream
// With ALLOW_WRITE_REQS at 0 a DM write raises a sticky error
// ========================================

`default_nettype none

module dm_req_splitter #(
    parameter int ALLOW_WRITE_REQS = 0
) (
    input  wire                          clk,
    input  wire                          rst_n,

    // Flit from the input skid stage with its decode flags
    input  wire                          i_valid,
    input  wire dm_split_pkg::t_tx_flit  i_flit,
    input  wire dm_split_pkg::t_flit_class i_class,
    output logic                         o_ready,

    // Output pieces
    output logic                         o_valid,
    output dm_split_pkg::t_tx_flit       o_flit,
    input  wire                          i_ready,

    output logic                         o_wr_error
);

    import dm_split_pkg::*;

    // ========================================
    // Holding register
    // ========================================

    logic        hold_valid;
    t_tx_flit    hold_flit;
    t_flit_class hold_class;
    // Bytes not yet covered by an emitted piece
    t_req_len    len_rem;
    // Start and length of the previous piece, zero length before the first
    t_req_addr   addr_prev;
    t_req_len    len_prev;
    logic        first_piece;
    logic        wr_error;

    // Piece in progress
    t_req_addr cur_addr;
    t_req_len  piece_max;
    t_req_len  piece_len;
    logic      is_last;
    logic      piece_last;
    t_tx_flit  out_flit;

    logic out_beat;
    logic in_load;

    // ========================================
    // Piece computation
    // ========================================

    always_comb begin
        // Each piece starts where the previous one ended
        cur_addr = addr_prev + t_req_addr'(len_prev);

        // The first piece runs up to the next REQ_MAX_BYTES boundary
        // Every later piece starts aligned and may use the full size
        if (first_piece) begin
            piece_max = t_req_len'(REQ_MAX_BYTES)
                      - t_req_len'(cur_addr[REQ_OFS_W-1:0]);
        end else begin
            piece_max = t_req_len'(REQ_MAX_BYTES);
        end

        is_last   = (len_rem <= piece_max);
        piece_len = is_last ? len_rem : piece_max;

        // A request that needs no split is its own last piece
        piece_last = !hold_class.needs_split || is_last;
    end

    // Header rewrite for the current piece
    always_comb begin
        out_flit = hold_flit;

        if (hold_class.needs_split) begin
            out_flit.hdr.length    = piece_len;
            out_flit.hdr.host_addr = cur_addr;
        end

        // Reads: the marker flags the piece that finishes the request
        // This also covers reads that were not split
        if (hold_class.is_mrd) begin
            out_flit.hdr.metadata[DM_METADATA_BIT] = piece_last;
        end

        // Writes: only split writes are touched
        if (hold_class.is_mwr && hold_class.needs_split) begin
            if (piece_last) begin
                // No commit will come back, so the marker tells that the last piece went out
                if (!hold_flit.user.commit_req) begin
                    out_flit.hdr.metadata[DM_METADATA_BIT] = 1'b1;
                end
            end else begin
                // Only the final piece may ask for a commit
                out_flit.user.commit_req = 1'b0;
                out_flit.hdr.metadata[DM_METADATA_BIT] = 1'b0;
            end
        end
    end

    // ========================================
    // Handshake
    // ========================================

    assign out_beat = hold_valid && i_ready;

    // A new flit loads in the cycle the final piece of the held one leaves
    assign o_ready = !hold_valid || (i_ready && piece_last);
    assign in_load = i_valid && o_ready;

    assign o_valid    = hold_valid;
    assign o_flit     = out_flit;
    assign o_wr_error = wr_error;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
            wr_error   <= 1'b0;
        end else begin
            if (in_load) begin
                // Once the error is up, incoming flits are swallowed
                hold_valid <= !wr_error;
            end else if (out_beat) begin
                hold_valid <= !piece_last;
            end

            // Sticky until reset
            if ((ALLOW_WRITE_REQS == 0) && hold_valid && hold_class.is_mwr) begin
                wr_error <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_load) begin
            hold_flit   <= i_flit;
            hold_class  <= i_class;
            len_rem     <= i_flit.hdr.length;
            addr_prev   <= i_flit.hdr.host_addr;
            len_prev    <= '0;
            first_piece <= 1'b1;
        end else if (out_beat) begin
            // Advance past the piece that just left
            addr_prev   <= cur_addr;
            len_prev    <= piece_len;
            len_rem     <= len_rem - piece_len;
            first_piece <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/dm_tx_split_top.sv
// ========================================
// TX request splitter of a host DMA channel
// Three cycles from input acceptance to the first piece without stalls
// ========================================

`default_nettype none

module dm_tx_split_top #(
    parameter int ALLOW_WRITE_REQS = 0
) (
    input  wire                         clk,
    input  wire                         rst_n,

    // Stream from the DMA engine
    input  wire                         i_tx_valid,
    input  wire dm_split_pkg::t_tx_flit i_tx_flit,
    output logic                        o_tx_ready,

    // Stream toward the PCIe core
    output logic                        o_tx_valid,
    output dm_split_pkg::t_tx_flit      o_tx_flit,
    input  wire                         i_tx_ready,

    // Sticky, set by a DM write when writes are disallowed
    output logic                        o_wr_error
);

    import dm_split_pkg::*;

    // Input skid to splitter
    logic        in_valid;
    t_tx_flit    in_flit;
    logic        in_ready;
    logic        in_beat;
    t_flit_class in_class;

    // Splitter to output skid
    logic     sp_valid;
    t_tx_flit sp_flit;
    logic     sp_ready;

    assign in_beat = in_valid && in_ready;

    axis_skid_stage u_in_skid (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (i_tx_valid),
        .i_flit  (i_tx_flit),
        .o_ready (o_tx_ready),
        .o_valid (in_valid),
        .o_flit  (in_flit),
        .i_ready (in_ready)
    );

    // Decode sits in front of the splitter within the same cycle
    dm_hdr_classify u_classify (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_flit  (in_flit),
        .i_beat  (in_beat),
        .o_class (in_class)
    );

    dm_req_splitter #(
        .ALLOW_WRITE_REQS (ALLOW_WRITE_REQS)
    ) u_splitter (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_valid    (in_valid),
        .i_flit     (in_flit),
        .i_class    (in_class),
        .o_ready    (in_ready),
        .o_valid    (sp_valid),
        .o_flit     (sp_flit),
        .i_ready    (sp_ready),
        .o_wr_error (o_wr_error)
    );

    axis_skid_stage u_out_skid (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (sp_valid),
        .i_flit  (sp_flit),
        .o_ready (sp_ready),
        .o_valid (o_tx_valid),
        .o_flit  (o_tx_flit),
        .i_ready (i_tx_ready)
    );

endmodule

`default_nettype wire

//--- tb/dm_tx_split_assertions.sv
// ========================================
// Output stream checks, bound into dm_tx_split_top
// Piece rules are checked on first flits of DM MRd and MWr packets only
// error_count is read by the testbench to stop the run
// ========================================

`default_nettype none

module dm_tx_split_assertions (
    input wire                         clk,
    input wire                         rst_n,
    input wire                         i_tx_ready,
    input wire                         o_tx_valid,
    input wire dm_split_pkg::t_tx_flit o_tx_flit,
    input wire                         o_wr_error
);

    timeunit 1ns;
    timeprecision 1ps;

    import dm_split_pkg::*;

    // One extra bit so that page offset plus length cannot wrap
    typedef logic [LEN_W:0] t_page_end;

    int        error_count = 0;
    logic      out_sop;
    logic      dm_hdr;
    t_page_end page_end;

    // Start of packet on the output side, advanced on every transfer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_sop <= 1'b1;
        end else if (o_tx_valid && i_tx_ready) begin
            out_sop <= o_tx_flit.last;
        end
    end

    assign dm_hdr = o_tx_valid && out_sop && o_tx_flit.user.dm_mode
                  && ((o_tx_flit.hdr.fmt_type == FMT_MRD) || (o_tx_flit.hdr.fmt_type == FMT_MWR));
    assign page_end = t_page_end'(o_tx_flit.hdr.host_addr[PAGE_OFS_W-1:0])
                    + t_page_end'(o_tx_flit.hdr.length);

    // ========================================
    // Properties
    // ========================================

    // A stalled beat stays put until it transfers
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (o_tx_valid && !i_tx_ready) |=> (o_tx_valid && $stable(o_tx_flit)))
        else begin
            $error("output beat changed while stalled");
            error_count = error_count + 1;
        end

    a_reset_idle: assert property (@(posedge clk) !rst_n |=> !o_tx_valid)
        else begin
            $error("output valid high right after reset");
            error_count = error_count + 1;
        end

    a_piece_len: assert property (@(posedge clk) disable iff (!rst_n)
        dm_hdr |-> (o_tx_flit.hdr.length <= t_req_len'(REQ_MAX_BYTES)))
        else begin
            $error("piece longer than REQ_MAX_BYTES");
            error_count = error_count + 1;
        end

    a_page_cross: assert property (@(posedge clk) disable iff (!rst_n)
        dm_hdr |-> (page_end <= t_page_end'(PAGE_BYTES)))
        else begin
            $error("piece crosses a page boundary");
            error_count = error_count + 1;
        end

    // Writes are allowed in this build
    a_no_wr_error: assert property (@(posedge clk) disable iff (!rst_n) !o_wr_error)
        else begin
            $error("write error flag raised");
            error_count = error_count + 1;
        end

endmodule

bind dm_tx_split_top dm_tx_split_assertions u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_tx_ready (i_tx_ready),
    .o_tx_valid (o_tx_valid),
    .o_tx_flit  (o_tx_flit),
    .o_wr_error (o_wr_error)
);

`default_nettype wire

//--- tb/dm_tx_split_tb.sv
// ========================================
// Testbench for dm_tx_split_top with writes allowed
// Every output beat is compared with a model queue under random back-pressure
// DM requests are single header flits, as the DUT assumes
// ========================================

`default_nettype none

module dm_tx_split_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import dm_split_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        i_tx_valid;
    t_tx_flit    i_tx_flit;
    logic        o_tx_ready;
    logic        o_tx_valid;
    t_tx_flit    o_tx_flit;
    logic        i_tx_ready;
    logic        o_wr_error;

    t_tx_flit    in_q[$];
    t_tx_flit    exp_q[$];
    integer      seed;
    int unsigned limit_cycles;
    int unsigned beat_cnt;
    logic        model_ready;

    dm_tx_split_top #(
        .ALLOW_WRITE_REQS (1)
    ) dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_tx_valid (i_tx_valid),
        .i_tx_flit  (i_tx_flit),
        .o_tx_ready (o_tx_ready),
        .o_tx_valid (o_tx_valid),
        .o_tx_flit  (o_tx_flit),
        .i_tx_ready (i_tx_ready),
        .o_wr_error (o_wr_error)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    // ========================================
    // Reference model of the piece rules
    // ========================================

    task automatic expect_request(input t_tx_flit f);
        t_tx_flit    e;
        t_req_addr   addr;
        int unsigned rem;
        int unsigned room;
        int unsigned piece;
        logic        is_rd;
        is_rd = (f.hdr.fmt_type == FMT_MRD);
        addr  = f.hdr.host_addr;
        rem   = f.hdr.length;
        if ((rem <= REQ_MAX_BYTES) && ((addr % PAGE_BYTES) + rem <= PAGE_BYTES)) begin
            // A request that fits passes as it is and only a read gets its marker
            e = f;
            if (is_rd) begin
                e.hdr.metadata[DM_METADATA_BIT] = 1'b1;
            end
            exp_q.push_back(e);
        end else begin
            // First piece stops at the next REQ_MAX_BYTES boundary
            room = REQ_MAX_BYTES - 32'(addr % REQ_MAX_BYTES);
            while (rem != 0) begin
                piece = (rem < room) ? rem : room;
                e = f;
                e.hdr.host_addr = addr;
                e.hdr.length = t_req_len'(piece);
                if (is_rd) begin
                    e.hdr.metadata[DM_METADATA_BIT] = (piece == rem);
                end else if (piece != rem) begin
                    e.user.commit_req = 1'b0;
                    e.hdr.metadata[DM_METADATA_BIT] = 1'b0;
                end else if (!f.user.commit_req) begin
                    e.hdr.metadata[DM_METADATA_BIT] = 1'b1;
                end
                exp_q.push_back(e);
                addr = addr + t_req_addr'(piece);
                rem  = rem - piece;
                room = REQ_MAX_BYTES;
            end
        end
    endtask

    task automatic add_dm_req(input logic [7:0] fmt, input t_req_addr addr,
                              input int unsigned len, input logic commit);
        t_tx_flit f;
        f.hdr.fmt_type = fmt;
        f.hdr.tag = 10'($random(seed));
        f.hdr.length = t_req_len'(len);
        f.hdr.host_addr = addr;
        f.hdr.metadata = {$random(seed), $random(seed)};
        f.user.dm_mode = 1'b1;
        f.user.commit_req = commit;
        f.last = 1'b1;
        in_q.push_back(f);
        if ((fmt == FMT_MRD) || (fmt == FMT_MWR)) begin
            expect_request(f);
        end else begin
            exp_q.push_back(f);
        end
    endtask

    // Packet that passes unchanged; flit 1 looks like a DM read to test sop gating
    task automatic add_raw_packet(input int unsigned nflits);
        t_tx_flit     f;
        logic [191:0] raw;
        for (int i = 0; i < nflits; i++) begin
            raw = {$random(seed), $random(seed), $random(seed),
                   $random(seed), $random(seed), $random(seed)};
            f.hdr = t_req_hdr'(raw[$bits(t_req_hdr)-1:0]);
            f.user = t_tx_user'(2'($random(seed)));
            f.last = (i == nflits - 1);
            if (i == 0) begin
                f.hdr.fmt_type = 8'h4A;
            end else if (i == 1) begin
                f.hdr.fmt_type = FMT_MRD;
                f.user.dm_mode = 1'b1;
            end
            in_q.push_back(f);
            exp_q.push_back(f);
        end
    endtask

    // ========================================
    // Stream drivers and checker
    // ========================================

    // Starts at a falling edge and returns at the falling edge after the transfer
    task automatic send_flit(input t_tx_flit f);
        i_tx_valid = 1'b1;
        i_tx_flit = f;
        while (!o_tx_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        i_tx_valid = 1'b0;
    endtask

    task automatic check_beat(input t_tx_flit got);
        t_tx_flit exp;
        if (exp_q.size() == 0) begin
            fail_run("output beat arrived when no more beats were expected");
        end else begin
            exp = exp_q.pop_front();
            if (got !== exp) begin
                fail_run($sformatf("mismatch at %0t: beat %0d expected %h, got %h",
                                   $time, beat_cnt, exp, got));
            end else begin
                beat_cnt++;
            end
        end
    endtask

    // Ready and outputs are all stable from the falling edge to the next rise
    initial begin
        logic [31:0] draw;
        @(negedge clk);
        while (dut.u_asserts.error_count == 0) begin
            draw = $random(seed);
            i_tx_ready = (draw[1:0] != 2'b00);
            if ((o_tx_valid === 1'b1) && i_tx_ready) begin
                check_beat(o_tx_flit);
            end
            @(negedge clk);
        end
        fail_run("a bound assertion on the output stream failed");
    end

    initial begin
        wait (model_ready);
        repeat (limit_cycles) @(posedge clk);
        fail_run($sformatf("run timed out with %0d beats still expected", exp_q.size()));
    end

    initial begin
        int unsigned pick;
        t_req_addr   addr;
        seed = 36;
        rst_n = 1'b0;
        i_tx_valid = 1'b0;
        i_tx_flit = '0;
        i_tx_ready = 1'b0;
        beat_cnt = 0;
        model_ready = 1'b0;

        // Pass-through, multi-flit and short DM requests
        add_raw_packet(1);
        add_raw_packet(3);
        add_dm_req(FMT_MRD, 64'h0000_0000_1000_0040, 64, 1'b0);
        add_dm_req(FMT_MWR, 64'h0000_0000_2000_0100, 128, 1'b1);
        add_dm_req(FMT_MWR, 64'h0000_0000_2000_0400, 200, 1'b0);
        add_dm_req(8'h4A, 64'h0000_0000_2000_0000, 4000, 1'b0);
        // Long reads from unaligned and aligned starts
        add_dm_req(FMT_MRD, 64'h0000_0001_0000_0030, 1000, 1'b0);
        add_dm_req(FMT_MRD, 64'h0000_0001_0000_3000, 1024, 1'b0);
        // Short requests across a page
        add_dm_req(FMT_MRD, 64'h0000_0000_5000_0FF0, 32, 1'b0);
        add_dm_req(FMT_MWR, 64'h0000_0000_5000_1FC0, 100, 1'b1);
        // Split writes with and without commit
        add_dm_req(FMT_MWR, 64'h0000_0000_6000_0080, 600, 1'b1);
        add_dm_req(FMT_MWR, 64'h0000_0000_6000_0010, 700, 1'b0);

        // Random mix of packet kinds
        for (int i = 0; i < 24; i++) begin
            pick = $unsigned($random(seed)) % 4;
            addr = {$random(seed), $random(seed)};
            if (pick == 0) begin
                add_raw_packet(($unsigned($random(seed)) % 3) + 1);
            end else begin
                add_dm_req((pick == 1) ? FMT_MRD : ((pick == 2) ? FMT_MWR : 8'h40), addr,
                           ($unsigned($random(seed)) % 1500) + 1, 1'($random(seed)));
            end
        end
        limit_cycles = exp_q.size() * 8 + 200;
        model_ready = 1'b1;

        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        while (in_q.size() != 0) begin
            send_flit(in_q.pop_front());
        end
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        // Extra beats after the last expected one would show up here
        repeat (20) @(negedge clk);
        if (dut.u_asserts.error_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            fail_run("a bound assertion on the output stream failed");
        end
    end

endmodule

`default_nettype wire

//--- dm_tx_split_top.f
verilog/dm_split_pkg.sv
verilog/axis_skid_stage.sv
verilog/dm_hdr_classify.sv
verilog/dm_req_splitter.sv
verilog/dm_tx_split_top.sv
tb/dm_tx_split_assertions.sv
tb/dm_tx_split_tb.sv

//--- Bender.yml
package:
  name: dm_tx_split

sources:
  - verilog/dm_split_pkg.sv
  - verilog/axis_skid_stage.sv
  - verilog/dm_hdr_classify.sv
  - verilog/dm_req_splitter.sv
  - verilog/dm_tx_split_top.sv
  - target: test
    files:
      - tb/dm_tx_split_assertions.sv
      - tb/dm_tx_split_tb.sv
